//--- aggre_line_sched.f
common/aggre_cfg_pkg.sv
common/aggre_sch_pkg.sv
common/pipe_lane_if.sv
verilog/aggre_cfg_regs.sv
verilog/multiple_value_comparator.sv
line_sched/line_sched_interleave.sv
verilog/bpg_line_gen.sv
verilog/aggre_line_sched_top.sv
sim/tb_clk_gen.sv
sim/tb_aggre_line_sched.sv

//--- Bender.yml
package:
  name: aggre_line_sched

sources:
  - common/aggre_cfg_pkg.sv
  - common/aggre_sch_pkg.sv
  - common/pipe_lane_if.sv
  - verilog/aggre_cfg_regs.sv
  - verilog/multiple_value_comparator.sv
  - line_sched/line_sched_interleave.sv
  - verilog/bpg_line_gen.sv
  - verilog/aggre_line_sched_top.sv
  - target: simulation
    files:
      - sim/tb_clk_gen.sv
      - sim/tb_aggre_line_sched.sv

//--- sim/tb_aggre_line_sched.sv
`timescale 1ns/1ps

module tb_aggre_line_sched;
    import aggre_sch_pkg::*;
    import aggre_cfg_pkg::*;

    localparam int bpg_len     = 8;
    localparam int timeout_cyc = 4000;   // Five tests of about 150 cycles plus margin

    logic                               aggre_clk;
    logic                               aggre_clk_rst_n;
    logic                               wb_cyc;
    logic                               wb_stb;
    logic                               wb_we;
    logic [1:0]                         wb_adr;
    logic [31:0]                        wb_wdata;
    logic [31:0]                        wb_rdata;
    logic                               wb_ack;
    logic                               start_sch_pulse;
    logic [pipe_num-1:0]                pipe_rdy_bitmap;
    logic [pipe_num-1:0]                dt_vld;
    logic [pipe_num-1:0][dt_width-1:0]  dt;
    logic [pipe_num-1:0]                ack;
    logic [pipe_num-1:0]                line_end;
    logic [pipe_num-1:0]                up_state_concat;
    logic                               end_sch_pulse;
    logic                               align_fail_int;

    integer              seed = 32'h1bb4_cc6e;
    int                  err_cnt = 0;
    int                  assert_cnt = 0;
    int                  cyc_cnt = 0;
    int                  end_cnt = 0;
    int                  grant_log[$];   // Pipe index per grant
    int                  grant_cyc[$];
    int                  le_cyc[pipe_num];
    int                  exp_seq[pipe_num];
    int                  exp_len;
    logic [pipe_num-1:0] up_prev = '0;
    logic [pipe_num-1:0] masked_bits = '0;
    logic [31:0]         rd_val;

    tb_clk_gen #(.CLK_PERIOD(40), .RST_CYCLES(4)) u_clk_gen (
        .aggre_clk       (aggre_clk),
        .aggre_clk_rst_n (aggre_clk_rst_n)
    );

    aggre_line_sched_top #(.DT_WIDTH(dt_width), .BPG_LINE_LEN(bpg_len)) DUT (.*);

    // ==============================
    // Helpers
    // ==============================
    function automatic int rand_between(input int lo, input int hi);
        return lo + ($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    function automatic void check_value(input string name, input logic [31:0] exp,
                                        input logic [31:0] act);
        assert (act === exp) else begin
            err_cnt++;
            $display("ERROR %s: expected 0x%0h, actual 0x%0h", name, exp, act);
        end
    endfunction

    task automatic wb_cycle(input logic we, input logic [1:0] adr, input logic [31:0] data);
        @(posedge aggre_clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_wdata <= data;
        do @(negedge aggre_clk); while (!wb_ack);
        rd_val = wb_rdata;
        @(posedge aggre_clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic write_reg(input logic [1:0] adr, input logic [31:0] data);
        wb_cycle(1'b1, adr, data);
    endtask

    task automatic read_reg(input logic [1:0] adr, output logic [31:0] data);
        wb_cycle(1'b0, adr, 32'd0);
        data = rd_val;
    endtask

    // Pipe answers its grant with a one cycle ack, then a one cycle line end
    task automatic serve_line(input int p);
        int ack_dly;
        int le_dly;
        ack_dly = rand_between(1, 4);
        le_dly  = rand_between(2, 6);
        repeat (ack_dly) @(posedge aggre_clk);
        ack[p] <= 1'b1;
        @(posedge aggre_clk);
        ack[p] <= 1'b0;
        repeat (le_dly - 1) @(posedge aggre_clk);
        line_end[p] <= 1'b1;
        @(posedge aggre_clk);
        line_end[p] <= 1'b0;
    endtask

    // Master first if ready, else lowest ready, then rising index with wrap
    task automatic build_expected(input logic [1:0] mst, input logic [3:0] rdy,
                                  input logic [3:0] msk);
        int first;
        int pipe;
        exp_len = 0;
        first   = -1;
        if (rdy[mst]) begin
            first = mst;
        end else begin
            for (int p = pipe_num - 1; p >= 0; p--) begin
                if (rdy[p]) first = p;
            end
        end
        if (first < 0) return;
        for (int k = 0; k < pipe_num; k++) begin
            pipe = (first + k) % pipe_num;
            if (rdy[pipe] && !msk[pipe]) begin
                exp_seq[exp_len] = pipe;
                exp_len++;
            end
        end
    endtask

    task automatic pulse_start(input logic [3:0] rdy);
        @(posedge aggre_clk);
        pipe_rdy_bitmap <= rdy;
        start_sch_pulse <= 1'b1;
        @(posedge aggre_clk);
        start_sch_pulse <= 1'b0;
    endtask

    task automatic run_schedule(input string name, input logic [1:0] mst,
                                input logic [3:0] rdy, input logic [3:0] msk);
        build_expected(mst, rdy, msk);
        grant_log.delete();
        grant_cyc.delete();
        end_cnt = 0;
        pulse_start(rdy);
        while (end_cnt == 0) @(posedge aggre_clk);
        repeat (4) @(posedge aggre_clk);   // Room for a stray second pulse
        check_value({name, " end pulses"}, 1, end_cnt);
        check_value({name, " grant count"}, exp_len, grant_log.size());
        for (int k = 0; k < exp_len && k < grant_log.size(); k++) begin
            check_value($sformatf("%s grant %0d", name, k), exp_seq[k], grant_log[k]);
        end
    endtask

    // ==============================
    // Pipe models and monitors
    // ==============================
    for (genvar p = 0; p < pipe_num; p++) begin : pipe_model
        initial begin
            forever begin
                @(negedge aggre_clk);
                if (up_state_concat[p]) begin
                    serve_line(p);
                end
            end
        end

        grant_held: assert property (@(posedge aggre_clk) disable iff (!aggre_clk_rst_n)
            up_state_concat[p] && !ack[p] |=> up_state_concat[p])
            else begin
                assert_cnt++;
                $display("Grant of pipe %0d dropped before its ack", p);
            end

        grant_falls_on_ack: assert property (@(posedge aggre_clk) disable iff (!aggre_clk_rst_n)
            $fell(up_state_concat[p]) |-> $past(ack[p]))
            else begin
                assert_cnt++;
                $display("Grant of pipe %0d fell without an ack", p);
            end
    end

    always @(negedge aggre_clk) begin
        for (int p = 0; p < pipe_num; p++) begin
            if (up_state_concat[p] && !up_prev[p]) begin
                grant_log.push_back(p);
                grant_cyc.push_back(cyc_cnt);
            end
            if (line_end[p]) begin
                le_cyc[p] = cyc_cnt;
            end
        end
        if (end_sch_pulse) begin
            end_cnt++;
        end
        up_prev = up_state_concat;
    end

    grant_onehot: assert property (@(posedge aggre_clk) disable iff (!aggre_clk_rst_n)
        $onehot0(up_state_concat))
        else begin
            assert_cnt++;
            $display("More than one pipe granted at once");
        end

    grant_only_ready: assert property (@(posedge aggre_clk) disable iff (!aggre_clk_rst_n)
        (up_state_concat & ~pipe_rdy_bitmap) == '0)
        else begin
            assert_cnt++;
            $display("A pipe that is not ready was granted");
        end

    grant_not_masked: assert property (@(posedge aggre_clk) disable iff (!aggre_clk_rst_n)
        (up_state_concat & masked_bits) == '0)
        else begin
            assert_cnt++;
            $display("A masked pipe saw its own grant");
        end

    end_pulse_short: assert property (@(posedge aggre_clk) disable iff (!aggre_clk_rst_n)
        end_sch_pulse |=> !end_sch_pulse)
        else begin
            assert_cnt++;
            $display("end_sch_pulse stayed high longer than one cycle");
        end

    wb_ack_short: assert property (@(posedge aggre_clk) disable iff (!aggre_clk_rst_n)
        wb_ack |=> !wb_ack)
        else begin
            assert_cnt++;
            $display("wb_ack stayed high longer than one cycle");
        end

    wb_ack_on_req: assert property (@(posedge aggre_clk) disable iff (!aggre_clk_rst_n)
        $rose(wb_ack) |-> $past(wb_cyc && wb_stb))
        else begin
            assert_cnt++;
            $display("wb_ack rose without a Wishbone request");
        end

    always @(posedge aggre_clk) begin
        cyc_cnt <= cyc_cnt + 1;
    end

    always @(negedge aggre_clk) begin
        if (cyc_cnt >= timeout_cyc) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_cyc);
            $display("Summary: %0d check errors, %0d assertion failures", err_cnt, assert_cnt);
            $display("Regression failed");
            $finish;
        end
    end

    // ==============================
    // Test sequence
    // ==============================
    initial begin
        wb_cyc          <= 1'b0;
        wb_stb          <= 1'b0;
        wb_we           <= 1'b0;
        wb_adr          <= 2'd0;
        wb_wdata        <= 32'd0;
        start_sch_pulse <= 1'b0;
        pipe_rdy_bitmap <= '0;
        dt_vld          <= '1;
        dt              <= {pipe_num{6'h1e}};   // All pipes agree
        ack             <= '0;
        line_end        <= '0;
        wait (aggre_clk_rst_n);
        @(posedge aggre_clk);

        // Register access
        write_reg(reg_ctrl, 32'h0000_0f19);   // concat F, irq, master 2, interleave
        read_reg(reg_ctrl, rd_val);
        check_value("reg_access ctrl", 32'h0000_0f19, rd_val);
        write_reg(reg_mask, 32'h0000_0005);
        read_reg(reg_mask, rd_val);
        check_value("reg_access mask", 32'h0000_0005, rd_val);
        write_reg(reg_mask, 32'h0000_0000);

        run_schedule("master_first", 2'd2, 4'b1111, 4'b0000);

        write_reg(reg_ctrl, 32'h0000_0f11);   // Master 0
        run_schedule("master_not_ready", 2'd0, 4'b1010, 4'b0000);

        // Pipe 1 served by the BPG
        write_reg(reg_mask, 32'h0000_0002);
        masked_bits <= 4'b0010;
        run_schedule("masked_pipe", 2'd0, 4'b1111, 4'b0010);
        if (grant_cyc.size() >= 2) begin
            check_value("masked_pipe gap", bpg_len + 5, grant_cyc[1] - le_cyc[0]);
        end
        write_reg(reg_mask, 32'h0000_0000);
        masked_bits <= 4'b0000;

        // Data type mismatch on pipes 0 and 2
        @(posedge aggre_clk);
        dt[2] <= 6'h2a;
        grant_log.delete();
        pulse_start(4'b0101);
        @(negedge aggre_clk);
        check_value("dt_mismatch irq", 1'b1, align_fail_int);
        repeat (4) @(posedge aggre_clk);
        check_value("dt_mismatch grants", 0, grant_log.size());
        read_reg(reg_status, rd_val);
        check_value("dt_mismatch status", 32'h0000_0001, rd_val);
        write_reg(reg_status, 32'h0000_0001);
        @(negedge aggre_clk);
        check_value("dt_mismatch irq clear", 1'b0, align_fail_int);
        read_reg(reg_status, rd_val);
        check_value("dt_mismatch status clear", 32'h0000_0000, rd_val);
        @(posedge aggre_clk);
        dt[2] <= 6'h1e;
        run_schedule("dt_match", 2'd0, 4'b0101, 4'b0000);

        $display("Summary: %0d check errors, %0d assertion failures", err_cnt, assert_cnt);
        if (err_cnt == 0 && assert_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- sim/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int CLK_PERIOD = 40,   // ns
    parameter int RST_CYCLES = 4
) (
    output logic aggre_clk,
    output logic aggre_clk_rst_n
);

    initial begin
        aggre_clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) aggre_clk = ~aggre_clk;
        end
    end

    // Reset held low for the first cycles
    initial begin
        aggre_clk_rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge aggre_clk);
        aggre_clk_rst_n <= 1'b1;
    end

endmodule

//--- verilog/aggre_line_sched_top.sv
`timescale 1ns/1ps

module aggre_line_sched_top #(
    parameter int DT_WIDTH     = aggre_sch_pkg::dt_width,
    parameter int BPG_LINE_LEN = 8
) (
    input  logic                                             aggre_clk,
    input  logic                                             aggre_clk_rst_n,
    input  logic                                             wb_cyc,
    input  logic                                             wb_stb,
    input  logic                                             wb_we,
    input  logic [1:0]                                       wb_adr,
    input  logic [31:0]                                      wb_wdata,
    output logic [31:0]                                      wb_rdata,
    output logic                                             wb_ack,
    input  logic                                             start_sch_pulse,
    input  logic [aggre_sch_pkg::pipe_num-1:0]               pipe_rdy_bitmap,
    input  logic [aggre_sch_pkg::pipe_num-1:0]               dt_vld,
    input  logic [aggre_sch_pkg::pipe_num-1:0][DT_WIDTH-1:0] dt,
    input  logic [aggre_sch_pkg::pipe_num-1:0]               ack,
    input  logic [aggre_sch_pkg::pipe_num-1:0]               line_end,
    output logic [aggre_sch_pkg::pipe_num-1:0]               up_state_concat,
    output logic                                             end_sch_pulse,
    output logic                                             align_fail_int
);
    import aggre_cfg_pkg::*;

    aggre_cfg_t cfg;
    logic       align_fail;
    logic       busy;
    logic       bpg_up_state;
    logic       bpg_ack;
    logic       bpg_line_end;

    pipe_lane_if #(.DT_WIDTH(DT_WIDTH)) lane ();

    // Pipe ports onto the lane bundle
    assign lane.ack         = ack;
    assign lane.line_end    = line_end;
    assign lane.dt_vld      = dt_vld;
    assign lane.dt          = dt;
    assign up_state_concat  = lane.up_state;

    aggre_cfg_regs u_cfg_regs (
        .aggre_clk       (aggre_clk),
        .aggre_clk_rst_n (aggre_clk_rst_n),
        .wb_cyc          (wb_cyc),
        .wb_stb          (wb_stb),
        .wb_we           (wb_we),
        .wb_adr          (wb_adr),
        .wb_wdata        (wb_wdata),
        .wb_rdata        (wb_rdata),
        .wb_ack          (wb_ack),
        .cfg             (cfg),
        .align_fail      (align_fail),
        .busy            (busy),
        .align_fail_int  (align_fail_int)
    );

    line_sched_interleave #(
        .DT_WIDTH (DT_WIDTH)
    ) u_sched (
        .aggre_clk       (aggre_clk),
        .aggre_clk_rst_n (aggre_clk_rst_n),
        .cfg             (cfg),
        .start_sch_pulse (start_sch_pulse),
        .pipe_rdy_bitmap (pipe_rdy_bitmap),
        .lane            (lane),
        .bpg_up_state    (bpg_up_state),
        .bpg_ack         (bpg_ack),
        .bpg_line_end    (bpg_line_end),
        .end_sch_pulse   (end_sch_pulse),
        .align_fail      (align_fail),
        .busy            (busy)
    );

    bpg_line_gen #(
        .BPG_LINE_LEN (BPG_LINE_LEN)
    ) u_bpg (
        .aggre_clk       (aggre_clk),
        .aggre_clk_rst_n (aggre_clk_rst_n),
        .bpg_up_state    (bpg_up_state),
        .bpg_ack         (bpg_ack),
        .bpg_line_end    (bpg_line_end)
    );

endmodule

//--- verilog/bpg_line_gen.sv
`timescale 1ns/1ps

module bpg_line_gen #(
    parameter int BPG_LINE_LEN = 8
) (
    input  logic aggre_clk,
    input  logic aggre_clk_rst_n,
    input  logic bpg_up_state,
    output logic bpg_ack,
    output logic bpg_line_end
);
    localparam int CNT_W = $clog2(BPG_LINE_LEN + 1);

    logic             grant_d;
    logic             grant_rise;
    logic             line_act;   // Blank line running
    logic [CNT_W-1:0] line_cnt;

    assign grant_rise = bpg_up_state & ~grant_d;

    always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
        if (!aggre_clk_rst_n) begin
            grant_d      <= 1'b0;
            bpg_ack      <= 1'b0;
            bpg_line_end <= 1'b0;
            line_act     <= 1'b0;
            line_cnt     <= '0;
        end else begin
            grant_d      <= bpg_up_state;
            bpg_ack      <= grant_rise;
            bpg_line_end <= line_act && (line_cnt == '0);
            if (grant_rise) begin
                line_act <= 1'b1;
                line_cnt <= CNT_W'(BPG_LINE_LEN - 1);   // Line end BPG_LINE_LEN after ack
            end else if (line_act) begin
                if (line_cnt == '0) begin
                    line_act <= 1'b0;
                end else begin
                    line_cnt <= line_cnt - 1'b1;
                end
            end
        end
    end

    // Scheduler waits for line end before the next grant
    no_mid_line_grant: assert property (@(posedge aggre_clk) disable iff (!aggre_clk_rst_n)
        $rose(bpg_up_state) |-> !line_act && !bpg_ack);

endmodule

//--- line_sched/line_sched_interleave.sv
`timescale 1ns/1ps

module line_sched_interleave #(
    parameter int DT_WIDTH = aggre_sch_pkg::dt_width
) (
    input  logic                               aggre_clk,
    input  logic                               aggre_clk_rst_n,
    input  aggre_cfg_pkg::aggre_cfg_t          cfg,
    input  logic                               start_sch_pulse,
    input  logic [aggre_sch_pkg::pipe_num-1:0] pipe_rdy_bitmap,
    pipe_lane_if.sched                         lane,
    output logic                               bpg_up_state,
    input  logic                               bpg_ack,
    input  logic                               bpg_line_end,
    output logic                               end_sch_pulse,
    output logic                               align_fail,
    output logic                               busy
);
    import aggre_cfg_pkg::*;
    import aggre_sch_pkg::*;

    sch_state_t          sch_cs;
    sch_state_t          sch_ns;
    sch_state_t          after_line;
    logic [2:0]          order_tbl [pipe_num];   // {ready, pipe index}
    logic [pipe_num-1:0] tbl_vld;
    logic [1:0]          sel_pos;
    logic [1:0]          sel_pipe;
    logic                use_master;
    logic [1:0]          issue_pipe;
    logic [1:0]          served_pos;
    logic [1:0]          cur_pipe;
    logic                master_first;
    logic [pipe_num-1:0] grant;
    logic [pipe_num-1:0] ack_concat;
    logic [pipe_num-1:0] line_end_concat;
    logic [pipe_num-1:0] cmp_vld;
    logic                cmp_fail;
    logic                start_ok;
    logic                start_go;
    logic                issue;
    logic                ack_hit;
    logic                line_done;

    // ==============================
    // Pipe and BPG masking
    // ==============================
    always_comb begin
        for (int i = 0; i < pipe_num; i++) begin
            ack_concat[i]      = cfg.concat_en[i] &
                                 (cfg.pipe_mask_bitmap[i] ? bpg_ack : lane.ack[i]);
            line_end_concat[i] = cfg.concat_en[i] &
                                 (cfg.pipe_mask_bitmap[i] ? bpg_line_end : lane.line_end[i]);
        end
    end

    assign lane.up_state = grant & ~cfg.pipe_mask_bitmap;
    assign bpg_up_state  = |(grant & cfg.pipe_mask_bitmap);   // Masked grant goes to BPG

    // Data type check at start
    assign start_ok = start_sch_pulse & (sch_cs == silent);    // Ignored while busy
    assign cmp_vld  = {pipe_num{start_ok}} & pipe_rdy_bitmap & lane.dt_vld;

    multiple_value_comparator #(
        .DT_WIDTH (DT_WIDTH)
    ) u_dt_cmp (
        .in_vld        (cmp_vld),
        .in_data       (lane.dt),
        .out_comp_fail (cmp_fail)
    );

    assign align_fail = cmp_fail & (cfg.aggre_mode == mode_line_interleave);
    assign start_go   = start_ok & ~align_fail & (|pipe_rdy_bitmap);

    // ==============================
    // Order table
    // ==============================
    always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
        if (!aggre_clk_rst_n) begin
            for (int i = 0; i < pipe_num; i++) begin
                order_tbl[i] <= 3'd0;
            end
        end else if (start_go) begin
            for (int i = 0; i < pipe_num; i++) begin
                order_tbl[i] <= {pipe_rdy_bitmap[i], 2'(i)};
            end
        end else if (ack_hit) begin
            // Served entry moves last and drops its ready bit
            for (int i = 0; i < pipe_num - 1; i++) begin
                order_tbl[i] <= order_tbl[2'(served_pos + i + 1)];
            end
            order_tbl[pipe_num-1] <= {1'b0, order_tbl[served_pos][1:0]};
        end
    end

    // Lowest valid position wins
    always_comb begin
        sel_pos = 2'd0;
        for (int i = pipe_num - 1; i >= 0; i--) begin
            tbl_vld[i] = order_tbl[i][2];
            if (order_tbl[i][2]) begin
                sel_pos = 2'(i);
            end
        end
    end

    assign sel_pipe = order_tbl[sel_pos][1:0];

    always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
        if (!aggre_clk_rst_n) begin
            master_first <= 1'b0;
        end else if (start_go) begin
            master_first <= pipe_rdy_bitmap[cfg.master_pipe];
        end
    end

    // ==============================
    // Grant issue and FSM
    // ==============================
    // At start the table is fresh, so position equals pipe index
    assign use_master = (sch_cs == start_concat) & master_first;
    assign issue_pipe = use_master ? cfg.master_pipe : sel_pipe;
    assign issue      = (sch_cs == start_concat) | ((sch_cs == order) & ~(|grant));
    assign ack_hit    = (sch_cs == wait_ack) & ack_concat[cur_pipe];
    assign line_done  = line_end_concat[cur_pipe];

    always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
        if (!aggre_clk_rst_n) begin
            grant      <= '0;
            served_pos <= 2'd0;
            cur_pipe   <= 2'd0;
        end else if (issue) begin
            grant      <= pipe_num'(1) << issue_pipe;
            served_pos <= use_master ? cfg.master_pipe : sel_pos;
            cur_pipe   <= issue_pipe;
        end else if (ack_hit) begin
            grant <= '0;   // Drops one edge after the ack
        end
    end

    assign after_line = (|tbl_vld) ? order : silent;

    always_comb begin
        sch_ns = sch_cs;
        case (sch_cs)
            silent:        if (start_go) sch_ns = start_concat;
            start_concat:  sch_ns = master_first ? master : order;
            master:        sch_ns = wait_ack;
            order:         sch_ns = wait_ack;
            wait_ack:      if (ack_hit) sch_ns = clear_state;
            clear_state:   sch_ns = line_done ? after_line : wait_line_end;
            wait_line_end: if (line_done) sch_ns = after_line;
            default:       sch_ns = silent;
        endcase
    end

    always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
        if (!aggre_clk_rst_n) begin
            sch_cs        <= silent;
            end_sch_pulse <= 1'b0;
        end else begin
            sch_cs        <= sch_ns;
            end_sch_pulse <= (sch_cs inside {clear_state, wait_line_end}) && (sch_ns == silent);
        end
    end

    assign busy = (sch_cs != silent);

    // Pipe and BPG grants together never exceed one
    grant_onehot: assert property (@(posedge aggre_clk) disable iff (!aggre_clk_rst_n)
        $onehot0({lane.up_state, bpg_up_state}));

    end_pulse_single: assert property (@(posedge aggre_clk) disable iff (!aggre_clk_rst_n)
        end_sch_pulse |=> !end_sch_pulse);

endmodule

//--- verilog/multiple_value_comparator.sv
`timescale 1ns/1ps

module multiple_value_comparator #(
    parameter int DT_WIDTH = aggre_sch_pkg::dt_width
) (
    input  logic [aggre_sch_pkg::pipe_num-1:0]               in_vld,
    input  logic [aggre_sch_pkg::pipe_num-1:0][DT_WIDTH-1:0] in_data,
    output logic                                             out_comp_fail
);
    import aggre_sch_pkg::*;

    // Pairwise check over valid inputs only
    always_comb begin
        out_comp_fail = 1'b0;
        for (int i = 0; i < pipe_num - 1; i++) begin
            for (int j = i + 1; j < pipe_num; j++) begin
                if (in_vld[i] && in_vld[j] && (in_data[i] != in_data[j])) begin
                    out_comp_fail = 1'b1;
                end
            end
        end
    end

endmodule

//--- verilog/aggre_cfg_regs.sv
`timescale 1ns/1ps

module aggre_cfg_regs (
    input  logic                      aggre_clk,
    input  logic                      aggre_clk_rst_n,
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  logic [1:0]                wb_adr,
    input  logic [31:0]               wb_wdata,
    output logic [31:0]               wb_rdata,
    output logic                      wb_ack,
    output aggre_cfg_pkg::aggre_cfg_t cfg,
    input  logic                      align_fail,
    input  logic                      busy,
    output logic                      align_fail_int
);
    import aggre_cfg_pkg::*;

    logic        wb_req;
    logic        wr_en;
    logic        fail_sticky;
    logic [31:0] rd_mux;

    assign wb_req = wb_cyc & wb_stb & ~wb_ack;   // One ack per classic cycle
    assign wr_en  = wb_req & wb_we;

    always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
        if (!aggre_clk_rst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= wb_req;
        end
    end

    // ==============================
    // Control and mask writes
    // ==============================
    always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
        if (!aggre_clk_rst_n) begin
            cfg <= '0;
        end else if (wr_en) begin
            case (wb_adr)
                reg_ctrl: begin
                    cfg.aggre_mode  <= wb_wdata[1:0];
                    cfg.master_pipe <= wb_wdata[3:2];
                    cfg.irq_en      <= wb_wdata[4];
                    cfg.concat_en   <= wb_wdata[11:8];
                end
                reg_mask: begin
                    cfg.pipe_mask_bitmap <= wb_wdata[3:0];
                end
                default: begin
                end
            endcase
        end
    end

    // New fail wins over the clear
    always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
        if (!aggre_clk_rst_n) begin
            fail_sticky <= 1'b0;
        end else if (align_fail) begin
            fail_sticky <= 1'b1;
        end else if (wr_en && (wb_adr == reg_status) && wb_wdata[0]) begin
            fail_sticky <= 1'b0;
        end
    end

    assign align_fail_int = fail_sticky & cfg.irq_en;

    always_comb begin
        case (wb_adr)
            reg_ctrl:   rd_mux = {20'd0, cfg.concat_en, 3'd0, cfg.irq_en,
                                  cfg.master_pipe, cfg.aggre_mode};
            reg_mask:   rd_mux = {28'd0, cfg.pipe_mask_bitmap};
            reg_status: rd_mux = {30'd0, busy, fail_sticky};
            default:    rd_mux = 32'd0;
        endcase
    end

    always_ff @(posedge aggre_clk) begin
        if (wb_req && !wb_we) begin
            wb_rdata <= rd_mux;   // Valid with wb_ack
        end
    end

    // Ack only answers a request the master still holds
    ack_needs_req: assert property (@(posedge aggre_clk) disable iff (!aggre_clk_rst_n)
        $rose(wb_ack) |-> $past(wb_cyc && wb_stb) && wb_cyc && wb_stb);

endmodule

//--- common/pipe_lane_if.sv
`timescale 1ns/1ps

interface pipe_lane_if #(
    parameter int DT_WIDTH = aggre_sch_pkg::dt_width
) ();
    import aggre_sch_pkg::*;

    logic [pipe_num-1:0]               up_state;   // Grant per pipe
    logic [pipe_num-1:0]               ack;
    logic [pipe_num-1:0]               line_end;
    logic [pipe_num-1:0]               dt_vld;
    logic [pipe_num-1:0][DT_WIDTH-1:0] dt;         // Data type code per pipe

    // Scheduler side
    modport sched (output up_state, input ack, line_end, dt_vld, dt);

    // Video source side
    modport src (input up_state, output ack, line_end, dt_vld, dt);

endinterface

//--- common/aggre_sch_pkg.sv
package aggre_sch_pkg;

    localparam int pipe_num = 4;   // Pipes sharing one line slot
    localparam int dt_width = 6;   // Data type code width

    // Scheduler FSM states
    typedef enum logic [2:0] {
        silent        = 3'd0,
        start_concat  = 3'd1,
        master        = 3'd2,
        order         = 3'd3,
        wait_ack      = 3'd4,
        clear_state   = 3'd5,
        wait_line_end = 3'd6
    } sch_state_t;

endpackage

//--- common/aggre_cfg_pkg.sv
package aggre_cfg_pkg;

    // ==============================
    // Wishbone register map
    // ==============================
    localparam logic [1:0] reg_ctrl   = 2'd0;   // mode, master, irq_en, concat_en
    localparam logic [1:0] reg_mask   = 2'd1;   // Pipe mask bitmap
    localparam logic [1:0] reg_status = 2'd2;   // align_fail (W1C), busy (RO)

    // Aggregation mode codes
    localparam logic [1:0] mode_line_interleave = 2'd1;

    // Configuration seen by the scheduler
    typedef struct packed {
        logic [1:0] aggre_mode;
        logic [3:0] concat_en;          // One enable per pipe
        logic [3:0] pipe_mask_bitmap;   // Set bit means BPG serves that pipe
        logic [1:0] master_pipe;
        logic       irq_en;
    } aggre_cfg_t;

endpackage
